/* Makefile */
# Verilator build and run of the coprocessor testbench
VERILATOR ?= verilator
TOP       ?= tb_cop
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
EXTRA     ?=

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* cop_bus_pkg.sv */
// Interface-side types of the coprocessor, the CPU request and response and memory request
package cop_bus_pkg;

    // Instruction request, valid while cpu_insn_req is high
    typedef struct packed {
        logic [31:0] insn_enc;   // Encoded instruction
        logic [31:0] rs1;        // CPU rs1 value
    } cop_req_t;

    // Response toward the CPU, held while cop_insn_rsp waits
    typedef struct packed {
        logic                     wen;     // Write CPU register
        logic [4:0]               waddr;   // CPU register index
        logic [31:0]              wdata;
        cop_isa_pkg::cop_result_e result;
    } cop_rsp_t;

    // Word-wide memory request, enable/stall protocol
    typedef struct packed {
        logic        cen;     // Chip enable, held until not stalled
        logic        wen;     // 1 for store
        logic [31:0] addr;    // Word aligned
        logic [31:0] wdata;
        logic [3:0]  ben;     // Always all ones
    } cop_mem_req_t;

endpackage

/* cop_decode.sv */
// Combinational instruction decoder, splits the encoding into fields and flags illegal ones
`timescale 1ns/1ns
`include "cop_settings.svh"

module cop_decode (
    input  logic [31:0]           insn_enc,   // Raw instruction word from the CPU
    output cop_isa_pkg::cop_dec_t dec         // Decoded fields to the execute stage
);

    import cop_isa_pkg::*;

    logic [6:0] major;          // Major opcode field
    logic [2:0] f3;             // Operation field
    logic       major_bad;
    logic       f3_bad;

    assign major = insn_enc[6:0];
    assign f3    = insn_enc[`COP_F3_LSB +: 3];

    // Anything outside custom-0 is not ours
    assign major_bad = (major != `COP_OPCODE);
    assign f3_bad    = (f3 == 3'd7);             // Reserved operation slot

    always_comb begin
        dec.op      = cop_op_e'(f3);             // Value 7 never reaches execution
        dec.illegal = major_bad || f3_bad;
        dec.rd      = insn_enc[`COP_RD_LSB  +: 5];
        dec.rs1     = insn_enc[`COP_RS1_LSB +: `COP_RIDX_W];
        dec.rs2     = insn_enc[`COP_RS2_LSB +: `COP_RIDX_W];
        dec.imm     = insn_enc[`COP_IMM_LSB +: 7];
    end

endmodule

/* cop_execute.sv */
// Execute stage of the coprocessor, control FSM, datapath, memory sequencing and response hold
`timescale 1ns/1ns
`include "cop_settings.svh"

module cop_execute (
    input  logic                       g_clk,
    input  logic                       arst_n,
    input  cop_bus_pkg::cop_req_t      req,         // Instruction and CPU rs1
    input  logic                       req_valid,
    output logic                       req_ready,
    input  cop_isa_pkg::cop_dec_t      dec,         // Decode of req.insn_enc
    input  logic [31:0]                rdata_a,     // Register at dec.rs1
    input  logic [31:0]                rdata_b,     // Register at dec.rs2
    output logic                       rf_we,
    output logic [`COP_RIDX_W-1:0]     rf_wa,
    output logic [31:0]                rf_wd,
    output cop_bus_pkg::cop_rsp_t      rsp,
    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output cop_bus_pkg::cop_mem_req_t  mem,
    input  logic [31:0]                mem_rdata,
    input  logic                       mem_stall,
    input  logic                       mem_error
);

    import cop_isa_pkg::*;
    import cop_bus_pkg::*;

    typedef enum logic [1:0] {s_idle, s_mem, s_rsp} cop_state_e;

    cop_state_e  state;
    logic        up_q;           // Low in reset and the first cycle after release
    cop_rsp_t    rsp_q;          // Response held for the CPU
    logic        st_q;           // Memory op in flight is a store
    logic [31:0] addr_q;         // Memory payload, no reset
    logic [31:0] wdata_q;
    logic        acc;            // Instruction handshake this cycle
    logic        is_mem;
    logic        mem_done;       // Non-stalled memory edge
    logic [63:0] rot_full;
    logic [31:0] alu_res;

    assign req_ready = (state == s_idle) && up_q;
    assign acc       = req_valid && req_ready;
    assign is_mem    = !dec.illegal && (dec.op == op_ld || dec.op == op_st);
    assign mem_done  = (state == s_mem) && !mem_stall;
    assign rot_full  = {rdata_a, rdata_a} >> dec.imm[4:0];   // Low half is the rotation

    always_comb begin
        case (dec.op)
            op_xor:    alu_res = rdata_a ^ rdata_b;
            op_add:    alu_res = rdata_a + rdata_b;
            op_rotr:   alu_res = rot_full[31:0];
            op_mv2cop: alu_res = req.rs1;
            default:   alu_res = rdata_a;                    // mv2gpr source
        endcase
    end

    // Register write at the edge entering s_rsp
    always_comb begin
        rf_we = 1'b0;
        rf_wa = dec.rd[`COP_RIDX_W-1:0];
        rf_wd = alu_res;
        if (state == s_mem) begin
            rf_wa = rsp_q.waddr[`COP_RIDX_W-1:0];            // Latched at acceptance
            rf_wd = mem_rdata;
            rf_we = mem_done && !st_q && !mem_error;         // Failed load writes nothing
        end else if (acc && !dec.illegal) begin
            rf_we = (dec.op == op_xor) || (dec.op == op_add) ||
                    (dec.op == op_rotr) || (dec.op == op_mv2cop);
        end
    end

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= s_idle;
            up_q         <= 1'b0;
            st_q         <= 1'b0;
            rsp_q.wen    <= 1'b0;
            rsp_q.waddr  <= '0;
            rsp_q.wdata  <= '0;
            rsp_q.result <= res_ok;
        end else begin
            up_q <= 1'b1;                                    // Ack opens one cycle after release
            case (state)
                s_idle: if (acc) begin
                    state        <= is_mem ? s_mem : s_rsp;
                    st_q         <= (dec.op == op_st);
                    rsp_q.wen    <= !dec.illegal && (dec.op == op_mv2gpr);
                    rsp_q.waddr  <= dec.rd;
                    rsp_q.wdata  <= alu_res;
                    rsp_q.result <= dec.illegal ? res_bad_insn : res_ok;
                end
                s_mem: if (mem_done) begin
                    state        <= s_rsp;
                    rsp_q.wdata  <= mem_rdata;               // Visible for debug only
                    rsp_q.result <= mem_error ? res_mem_err : res_ok;
                end
                default: if (rsp_ready) begin                // Response taken
                    state     <= s_idle;
                    rsp_q.wen <= 1'b0;
                end
            endcase
        end
    end

    // Address is CPU rs1 plus unsigned word offset, store data from crs2
    always_ff @(posedge g_clk) begin
        if (acc) begin
            addr_q  <= req.rs1 + {23'd0, dec.imm, 2'b00};
            wdata_q <= rdata_b;
        end
    end

    assign rsp_valid = (state == s_rsp);
    assign rsp       = rsp_q;

    always_comb begin
        mem.cen   = (state == s_mem);
        mem.wen   = st_q;
        mem.addr  = addr_q;
        mem.wdata = wdata_q;
        mem.ben   = 4'hf;                                    // Word access only
    end

endmodule

/* cop_isa_pkg.sv */
// Instruction-side types of the coprocessor, imported by the decoder, execute stage and top
`include "cop_settings.svh"

package cop_isa_pkg;

    // Operation select, taken from bits 14:12 of the encoding
    // Value 7 has no operation and is flagged illegal by the decoder
    typedef enum logic [2:0] {
        op_xor    = 3'd0,   // crd = crs1 ^ crs2
        op_add    = 3'd1,   // crd = crs1 + crs2, modulo 2^32
        op_rotr   = 3'd2,   // crd = crs1 rotated right by imm[4:0]
        op_ld     = 3'd3,   // crd = mem[rs1 + imm*4]
        op_st     = 3'd4,   // mem[rs1 + imm*4] = crs2
        op_mv2cop = 3'd5,   // crd = CPU rs1 value
        op_mv2gpr = 3'd6    // CPU rd = crs1
    } cop_op_e;

    // Result code returned with every response
    typedef enum logic [2:0] {
        res_ok       = 3'd0,
        res_bad_insn = 3'd1,   // Wrong major opcode or reserved operation
        res_mem_err  = 3'd2    // Memory error on load or store
    } cop_result_e;

    // Decoded instruction fields
    typedef struct packed {
        cop_op_e                 op;
        logic                    illegal;
        logic [4:0]              rd;     // CPU rd for mv2gpr, low bits index coprocessor rd
        logic [`COP_RIDX_W-1:0]  rs1;
        logic [`COP_RIDX_W-1:0]  rs2;
        logic [6:0]              imm;    // Unsigned, word offset or rotate amount
    } cop_dec_t;

endpackage

/* cop_regfile.sv */
// Coprocessor register file, two asynchronous read ports and one synchronous write port
`timescale 1ns/1ns
`include "cop_settings.svh"

module cop_regfile (
    input  logic                   g_clk,
    input  logic                   arst_n,
    input  logic [`COP_RIDX_W-1:0] ra,        // Read port A index
    input  logic [`COP_RIDX_W-1:0] rb,        // Read port B index
    output logic [31:0]            rdata_a,
    output logic [31:0]            rdata_b,
    input  logic                   we,        // Write strobe
    input  logic [`COP_RIDX_W-1:0] wa,
    input  logic [31:0]            wd
);

    logic [31:0] regs [`COP_NREGS];

    // Reads see the stored value, no bypass of a same-cycle write
    assign rdata_a = regs[ra];
    assign rdata_b = regs[rb];

    // All registers start at zero
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `COP_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

endmodule

/* cop_settings.svh */
// Shared coprocessor constants and instruction field positions, included by packages and RTL
`ifndef COP_SETTINGS_SVH
`define COP_SETTINGS_SVH

`define COP_NREGS   16          // Coprocessor register count
`define COP_RIDX_W  4           // Register index width

// Major opcode, custom-0 space
`define COP_OPCODE  7'b0001011

// Field positions in the instruction word, low bit of each field
`define COP_RD_LSB  7           // rd, 5 bits
`define COP_F3_LSB  12          // Operation select, 3 bits
`define COP_RS1_LSB 15          // Coprocessor rs1, 4 bits
`define COP_RS2_LSB 20          // Coprocessor rs2, 4 bits
`define COP_IMM_LSB 25          // Immediate, 7 bits

`endif

/* cop_sva.sv */
// Handshake and memory bus assertions for the coprocessor, bound into cop_top by the testbench build
`timescale 1ns/1ns

module cop_sva (
    input logic        g_clk,
    input logic        arst_n,
    input logic        cop_insn_ack,
    input logic        cop_insn_rsp,
    input logic        cpu_insn_ack,
    input logic        cop_wen,
    input logic [4:0]  cop_waddr,
    input logic [31:0] cop_wdata,
    input logic [2:0]  cop_result,
    input logic        cop_mem_cen,
    input logic        cop_mem_stall,
    input logic        cop_mem_wen,
    input logic [31:0] cop_mem_addr,
    input logic [31:0] cop_mem_wdata,
    input logic [3:0]  cop_mem_ben
);

    // Only one side of the FSM is open at a time
    a_ack_rsp_excl: assert property (@(posedge g_clk) disable iff (!arst_n)
        !(cop_insn_ack && cop_insn_rsp))
        else $error("instruction ack and response valid high together");

    // Response held until the CPU takes it
    a_rsp_stable: assert property (@(posedge g_clk) disable iff (!arst_n)
        (cop_insn_rsp && !cpu_insn_ack) |=>
        (cop_insn_rsp && $stable({cop_wen, cop_waddr, cop_wdata, cop_result})))
        else $error("response changed while waiting for the CPU");

    // Stalled request keeps its payload
    a_mem_stable: assert property (@(posedge g_clk) disable iff (!arst_n)
        (cop_mem_cen && cop_mem_stall) |=>
        (cop_mem_cen && $stable({cop_mem_wen, cop_mem_addr, cop_mem_wdata, cop_mem_ben})))
        else $error("memory request changed during a stall");

    a_wen_rsp: assert property (@(posedge g_clk) disable iff (!arst_n)
        cop_wen |-> cop_insn_rsp)
        else $error("CPU register write strobe without a response");

endmodule

bind cop_top cop_sva i_sva (
    .g_clk         (g_clk),
    .arst_n        (arst_n),
    .cop_insn_ack  (cop_insn_ack),
    .cop_insn_rsp  (cop_insn_rsp),
    .cpu_insn_ack  (cpu_insn_ack),
    .cop_wen       (cop_wen),
    .cop_waddr     (cop_waddr),
    .cop_wdata     (cop_wdata),
    .cop_result    (cop_result),
    .cop_mem_cen   (cop_mem_cen),
    .cop_mem_stall (cop_mem_stall),
    .cop_mem_wen   (cop_mem_wen),
    .cop_mem_addr  (cop_mem_addr),
    .cop_mem_wdata (cop_mem_wdata),
    .cop_mem_ben   (cop_mem_ben)
);

/* cop_top.sv */
// Coprocessor top level, maps the CPU and memory ports onto the decoder, registers and execute stage
`timescale 1ns/1ns
`include "cop_settings.svh"

module cop_top (
    input  logic        g_clk,
    input  logic        arst_n,
    input  logic        cpu_insn_req,    // Instruction valid
    output logic        cop_insn_ack,    // Instruction ready
    input  logic [31:0] cpu_insn_enc,
    input  logic [31:0] cpu_rs1,
    output logic        cop_wen,         // CPU register write
    output logic [4:0]  cop_waddr,
    output logic [31:0] cop_wdata,
    output logic [2:0]  cop_result,
    output logic        cop_insn_rsp,    // Response valid
    input  logic        cpu_insn_ack,    // Response ready
    output logic        cop_mem_cen,
    output logic        cop_mem_wen,
    output logic [31:0] cop_mem_addr,
    output logic [31:0] cop_mem_wdata,
    input  logic [31:0] cop_mem_rdata,
    output logic [3:0]  cop_mem_ben,
    input  logic        cop_mem_stall,
    input  logic        cop_mem_error
);

    import cop_isa_pkg::*;
    import cop_bus_pkg::*;

    cop_req_t               req;
    cop_dec_t               dec;
    cop_rsp_t               rsp;
    cop_mem_req_t           mem;
    logic [31:0]            rdata_a;
    logic [31:0]            rdata_b;
    logic                   rf_we;
    logic [`COP_RIDX_W-1:0] rf_wa;
    logic [31:0]            rf_wd;

    assign req.insn_enc = cpu_insn_enc;
    assign req.rs1      = cpu_rs1;

    assign cop_wen    = rsp.wen;
    assign cop_waddr  = rsp.waddr;
    assign cop_wdata  = rsp.wdata;
    assign cop_result = rsp.result;

    assign cop_mem_cen   = mem.cen;
    assign cop_mem_wen   = mem.wen;
    assign cop_mem_addr  = mem.addr;
    assign cop_mem_wdata = mem.wdata;
    assign cop_mem_ben   = mem.ben;

    cop_decode u_decode (
        .insn_enc (req.insn_enc),
        .dec      (dec)
    );

    // Source fields index the read ports directly
    cop_regfile u_regfile (
        .g_clk   (g_clk),
        .arst_n  (arst_n),
        .ra      (dec.rs1),
        .rb      (dec.rs2),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (rf_we),
        .wa      (rf_wa),
        .wd      (rf_wd)
    );

    cop_execute u_execute (
        .g_clk     (g_clk),
        .arst_n    (arst_n),
        .req       (req),
        .req_valid (cpu_insn_req),
        .req_ready (cop_insn_ack),
        .dec       (dec),
        .rdata_a   (rdata_a),
        .rdata_b   (rdata_b),
        .rf_we     (rf_we),
        .rf_wa     (rf_wa),
        .rf_wd     (rf_wd),
        .rsp       (rsp),
        .rsp_valid (cop_insn_rsp),
        .rsp_ready (cpu_insn_ack),
        .mem       (mem),
        .mem_rdata (cop_mem_rdata),
        .mem_stall (cop_mem_stall),
        .mem_error (cop_mem_error)
    );

endmodule

/* tb_cop.sv */
// Directed testbench for cop_top, top module tb_cop with memory model and register reference
`timescale 1ns/1ns
`include "cop_settings.svh"

module tb_cop;

    import cop_isa_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;   // Roughly four times the longest stalled run

    logic        g_clk, arst_n;
    logic        cpu_insn_req, cop_insn_ack, cop_insn_rsp, cpu_insn_ack;
    logic [31:0] cpu_insn_enc, cpu_rs1, cop_wdata;
    logic        cop_wen;
    logic [4:0]  cop_waddr;
    logic [2:0]  cop_result;
    logic        cop_mem_cen, cop_mem_wen, cop_mem_stall, cop_mem_error;
    logic [31:0] cop_mem_addr, cop_mem_wdata, cop_mem_rdata;
    logic [3:0]  cop_mem_ben;

    logic [31:0] mem_model [64];            // Word memory, byte address bits 7:2
    logic [31:0] ref_regs [16];             // Expected coprocessor registers
    logic [31:0] lfsr;
    logic        err_on;                    // Error injection for the next access
    logic [31:0] last_addr;                 // Last completed memory access
    logic [3:0]  last_ben;
    logic        last_wen;
    logic        r_wen;                     // Captured response
    logic [4:0]  r_waddr;
    logic [31:0] r_wdata;
    logic [2:0]  r_result;
    int          cycles = 0;

    cop_top i_dut (.*);

    always #5 g_clk = ~g_clk;

    // Run limit
    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // x^32+x^22+x^2+x+1
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};       // One step per bit
        end
    endtask

    function automatic logic [31:0] rotr(input logic [31:0] a, input logic [4:0] s);
        if (s == 5'd0) return a;
        return (a >> s) | (a << (6'd32 - {1'b0, s}));
    endfunction

    function automatic logic [31:0] enc(input logic [2:0] op, input logic [4:0] rd,
                                        input logic [3:0] rs1, input logic [3:0] rs2,
                                        input logic [6:0] imm);
        logic [31:0] e;
        e = '0;
        e[6:0]                 = `COP_OPCODE;
        e[`COP_F3_LSB  +: 3]   = op;
        e[`COP_RD_LSB  +: 5]   = rd;
        e[`COP_RS1_LSB +: 4]   = rs1;
        e[`COP_RS2_LSB +: 4]   = rs2;
        e[`COP_IMM_LSB +: 7]   = imm;
        return e;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Memory side, driven with the other inputs just after the edge
    task automatic drive_mem();
        logic [31:0] b;
        b = '0;
        if (cop_mem_cen) draw(1, b);        // Random stall only while enabled
        cop_mem_stall = b[0];
        cop_mem_error = cop_mem_cen && !b[0] && err_on;
        cop_mem_rdata = mem_model[cop_mem_addr[7:2]];
        if (cop_mem_cen && !b[0]) begin      // Completes at the next edge
            last_addr = cop_mem_addr;
            last_ben  = cop_mem_ben;
            last_wen  = cop_mem_wen;
            if (cop_mem_wen && !err_on) mem_model[cop_mem_addr[7:2]] = cop_mem_wdata;
        end
    endtask

    task automatic step();
        @(posedge g_clk);
        #1;
        drive_mem();
    endtask

    // One instruction, response held back for hold cycles with the next request waiting
    task automatic issue(input logic [31:0] insn, input logic [31:0] rs1, input logic fast,
                         input int hold = 0);
        cpu_insn_req = 1'b1;
        cpu_insn_enc = insn;
        cpu_rs1      = rs1;
        while (!cop_insn_ack) step();
        step();                             // Accepted here
        cpu_insn_req = 1'b0;
        if (fast) check("cop_insn_rsp", 32'(cop_insn_rsp), 32'd1);
        else check("cop_mem_cen", 32'(cop_mem_cen), 32'd1);
        while (!cop_insn_rsp) step();
        r_wen    = cop_wen;
        r_waddr  = cop_waddr;
        r_wdata  = cop_wdata;
        r_result = cop_result;
        cpu_insn_req = (hold > 0);
        for (int i = 0; i < hold; i++) begin
            step();
            check("cop_insn_ack", 32'(cop_insn_ack), 32'd0);   // Pending request waits
            check("cop_insn_rsp", 32'(cop_insn_rsp), 32'd1);
            check("cop_wen", 32'(cop_wen), 32'(r_wen));
            check("cop_wdata", cop_wdata, r_wdata);
            check("cop_waddr", 32'(cop_waddr), 32'(r_waddr));
            check("cop_result", 32'(cop_result), 32'(r_result));
        end
        cpu_insn_ack = 1'b1;
        step();
        cpu_insn_ack = 1'b0;
        cpu_insn_req = 1'b0;
        check("cop_insn_rsp", 32'(cop_insn_rsp), 32'd0);       // Response taken
        check("cop_insn_ack", 32'(cop_insn_ack), 32'd1);
    endtask

    task automatic expect_quiet(input logic [2:0] res);
        check("cop_result", 32'(r_result), 32'(res));
        check("cop_wen", 32'(r_wen), 32'd0);
    endtask

    task automatic put_reg(input logic [3:0] idx, input logic [31:0] val);
        issue(enc(op_mv2cop, {1'b0, idx}, 4'd0, 4'd0, 7'd0), val, 1'b1);
        expect_quiet(res_ok);
        ref_regs[idx] = val;
    endtask

    // Read back into CPU register 16 + idx
    task automatic expect_reg(input logic [3:0] idx, input int hold = 0);
        issue(enc(op_mv2gpr, {1'b1, idx}, idx, 4'd0, 7'd0), 32'd0, 1'b1, hold);
        check("cop_wen", 32'(r_wen), 32'd1);
        check("cop_waddr", 32'(r_waddr), 32'({1'b1, idx}));
        check("cop_wdata", r_wdata, ref_regs[idx]);
        check("cop_result", 32'(r_result), 32'(res_ok));
    endtask

    task automatic alu(input logic [2:0] op, input logic [3:0] rd, input logic [6:0] imm,
                       input logic [31:0] exp);
        issue(enc(op, {1'b0, rd}, 4'd1, 4'd2, imm), 32'd0, 1'b1);
        expect_quiet(res_ok);
        ref_regs[rd] = exp;
    endtask

    task automatic test_reset_moves();
        logic [31:0] v;
        check("cop_insn_ack", 32'(cop_insn_ack), 32'd0);   // Ready one cycle after release
        check("cop_insn_rsp", 32'(cop_insn_rsp), 32'd0);
        check("cop_mem_cen", 32'(cop_mem_cen), 32'd0);
        check("cop_wen", 32'(cop_wen), 32'd0);
        step();
        check("cop_insn_ack", 32'(cop_insn_ack), 32'd1);
        expect_reg(4'd9);                   // Never written
        draw(32, v);
        put_reg(4'd3, v);
        draw(32, v);
        put_reg(4'd12, v);
        expect_reg(4'd3);
        expect_reg(4'd12);
    endtask

    task automatic test_arith();
        logic [31:0] a, b, amt;
        repeat (6) begin
            draw(32, a);
            draw(32, b);
            draw(7, amt);                   // Upper imm bits must be ignored
            put_reg(4'd1, a);
            put_reg(4'd2, b);
            alu(op_xor, 4'd4, 7'd0, a ^ b);
            alu(op_add, 4'd5, 7'd0, a + b);
            alu(op_rotr, 4'd6, amt[6:0], rotr(a, amt[4:0]));
            expect_reg(4'd4);
            expect_reg(4'd5);
            expect_reg(4'd6);
        end
    endtask

    task automatic test_memory();
        logic [31:0] base, imm, data, rs1, addr;
        repeat (6) begin
            draw(4, base);
            draw(5, imm);
            draw(32, data);
            rs1  = {26'd0, base[3:0], 2'b00};
            addr = rs1 + {25'd0, imm[4:0], 2'b00};
            put_reg(4'd7, data);
            issue(enc(op_st, 5'd0, 4'd0, 4'd7, {2'b00, imm[4:0]}), rs1, 1'b0);
            expect_quiet(res_ok);
            check("cop_mem_addr", last_addr, addr);
            check("cop_mem_ben", 32'(last_ben), 32'hf);
            check("cop_mem_wen", 32'(last_wen), 32'd1);
            check("mem_model", mem_model[addr[7:2]], data);
            issue(enc(op_ld, 5'd8, 4'd0, 4'd0, {2'b00, imm[4:0]}), rs1, 1'b0);
            expect_quiet(res_ok);
            check("cop_mem_addr", last_addr, addr);
            check("cop_mem_wen", 32'(last_wen), 32'd0);
            ref_regs[8] = data;
            expect_reg(4'd8);
        end
    endtask

    task automatic test_mem_error();
        put_reg(4'd8, 32'hdead_5a5a);
        err_on = 1'b1;
        issue(enc(op_ld, 5'd8, 4'd0, 4'd0, 7'd3), 32'd16, 1'b0);
        err_on = 1'b0;
        expect_quiet(res_mem_err);
        expect_reg(4'd8);                   // Target untouched
    endtask

    task automatic test_illegal();
        logic [31:0] bad;
        bad      = enc(op_mv2gpr, 5'd4, 4'd4, 4'd0, 7'd0);
        bad[6:0] = 7'b0110011;              // Not custom-0
        issue(bad, 32'd0, 1'b1);
        expect_quiet(res_bad_insn);
        bad      = enc(op_mv2cop, 5'd5, 4'd0, 4'd0, 7'd0);
        bad[6:0] = 7'b0101011;              // Custom-1, would overwrite crd 5
        issue(bad, ~ref_regs[5], 1'b1);
        expect_quiet(res_bad_insn);
        issue(enc(3'd7, 5'd4, 4'd1, 4'd2, 7'd0), 32'd0, 1'b1);
        expect_quiet(res_bad_insn);
        expect_reg(4'd4);
        expect_reg(4'd5);
    endtask

    initial begin
        g_clk         = 1'b0;
        arst_n        = 1'b0;
        cpu_insn_req  = 1'b0;
        cpu_insn_ack  = 1'b0;
        cpu_insn_enc  = '0;
        cpu_rs1       = '0;
        cop_mem_rdata = '0;
        cop_mem_stall = 1'b0;
        cop_mem_error = 1'b0;
        err_on        = 1'b0;
        lfsr          = 32'h716f04e1;
        for (int i = 0; i < 64; i++) mem_model[i] = ~(32'(i) * 32'h9e3779b9);
        for (int i = 0; i < 16; i++) ref_regs[i] = '0;
        repeat (8) @(posedge g_clk);
        #1 arst_n = 1'b1;
        test_reset_moves();
        test_arith();
        test_memory();
        test_mem_error();
        test_illegal();
        expect_reg(4'd4, 5);                // Response held back by the CPU
        expect_reg(4'd5);
        $display("Test OK");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
cop_isa_pkg.sv
cop_bus_pkg.sv
cop_decode.sv
cop_regfile.sv
cop_execute.sv
cop_top.sv
cop_sva.sv
tb_cop.sv
